// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_idt_sequencer
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# A $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: common/idt_params.svh
`ifndef IDT_PARAMS_SVH
`define IDT_PARAMS_SVH

// Vector numbers
`define IDT_VEC_PROTECTION  32'd13
`define IDT_VEC_PAGE_FAULT  32'd14
`define IDT_VEC_INTERRUPT   32'd15

`define IDT_GATE_SHIFT      3           // 8-byte gates

// Injected opcode bytes, first byte at the left
`define OPC_PUSH_IMM        8'h68
`define OPC_MOV_EAX_MOFFS   8'hA1
`define OPC_XCHG_AX_BX      16'h6693
`define OPC_SAR_EAX_4       24'hC1F804
`define OPC_MOV_CS_AX       24'h668EC8
`define OPC_JMP_EBX         16'hFFE3
`define OPC_RET_FAR         8'hCB
`define OPC_POP_EFLAGS      8'h58       // POP into EAX, loads EFLAGS

`endif

// File: common/idt_pkg.sv
package idt_pkg;

    // One-hot-ish cause from write-back, lowest bit wins
    typedef struct packed {
        logic interrupt;    // bit 2
        logic page_fault;   // bit 1
        logic protection;   // bit 0
    } ie_cause_t;

    typedef enum logic [3:0] {
        IDLE        = 4'd0,
        FLUSH       = 4'd1,
        PUSH_EFLAGS = 4'd2,
        PUSH_CS     = 4'd3,
        PUSH_EIP    = 4'd4,
        LOAD_LO     = 4'd5,
        LOAD_HI     = 4'd6,
        XCHG        = 4'd7,
        SAR         = 4'd8,
        MOV_CS      = 4'd9,
        JMP         = 4'd10,
        RET_FAR     = 4'd11,
        POP_EFLAGS  = 4'd12
    } seq_state_t;

    typedef struct packed {
        logic [31:0] eip;
        logic [15:0] cs;
        logic [17:0] eflags;
    } wb_context_t;

    // Gate entry, low and high dwords
    typedef struct packed {
        logic [31:0] entry_lo;
        logic [31:0] entry_hi;
    } gate_addr_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [31:0] imm32;     // little-endian bytes
        logic [87:0] pad;
    } imm_form_t;

    // Fetch packet, byte 0 is the first instruction byte
    typedef union packed {
        logic [0:15][7:0] raw;
        imm_form_t        imm_form;
    } fetch_packet_u;

endpackage

// File: design/idt_sequencer_top.sv
module idt_sequencer_top
    import idt_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          enable,
    input  logic          ie,
    input  ie_cause_t     ie_cause,
    input  logic [31:0]   idt_base,
    input  wb_context_t   wb_ctx,
    input  logic          is_iretd,
    output fetch_packet_u packet,
    output logic          packet_select,
    output logic          flush_pipe,
    output logic          ld_eip,
    output logic          is_pop_eflags
);

    gate_addr_t  gate;
    gate_addr_t  gate_q;
    seq_state_t  state;
    wb_context_t ctx_q;

    ie_decode ie_decode_inst (
        .ie_cause (ie_cause),
        .idt_base (idt_base),
        .gate     (gate)
    );

    ie_sequencer ie_sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .ie            (ie),
        .is_iretd      (is_iretd),
        .gate          (gate),
        .wb_ctx        (wb_ctx),
        .state         (state),
        .ctx_q         (ctx_q),
        .gate_q        (gate_q),
        .packet_select (packet_select),
        .flush_pipe    (flush_pipe),
        .ld_eip        (ld_eip),
        .is_pop_eflags (is_pop_eflags)
    );

    packet_builder packet_builder_inst (
        .state  (state),
        .ctx_q  (ctx_q),
        .gate_q (gate_q),
        .packet (packet)
    );

endmodule

// File: design/ie_decode.sv
`include "idt_params.svh"

module ie_decode
    import idt_pkg::*;
(
    input  ie_cause_t   ie_cause,
    input  logic [31:0] idt_base,
    output gate_addr_t  gate
);

    logic [31:0] vector;
    logic [31:0] gate_offset;
    logic [31:0] entry_lo;

    // Protection beats page fault beats interrupt
    always_comb begin
        if (ie_cause.protection) begin
            vector = `IDT_VEC_PROTECTION;
        end else if (ie_cause.page_fault) begin
            vector = `IDT_VEC_PAGE_FAULT;
        end else if (ie_cause.interrupt) begin
            vector = `IDT_VEC_INTERRUPT;
        end else begin
            vector = '0;
        end
    end

    assign gate_offset = vector << `IDT_GATE_SHIFT;
    assign entry_lo    = idt_base + gate_offset;

    assign gate.entry_lo = entry_lo;
    assign gate.entry_hi = entry_lo + 32'd4;    // second dword of the gate

    // Write-back always presents a cause, even between requests
    always_comb begin
        if (!$isunknown(ie_cause)) begin
            assert (ie_cause != '0)
                else $error("ie_decode: empty cause at %0t", $time);
        end
    end

endmodule

// File: design/ie_sequencer.sv
module ie_sequencer
    import idt_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic        ie,
    input  logic        is_iretd,
    input  gate_addr_t  gate,
    input  wb_context_t wb_ctx,
    output seq_state_t  state,
    output wb_context_t ctx_q,
    output gate_addr_t  gate_q,
    output logic        packet_select,
    output logic        flush_pipe,
    output logic        ld_eip,
    output logic        is_pop_eflags
);

    seq_state_t next_state;
    logic       capture;

    assign capture = (state == IDLE) && ie;

    always_comb begin
        case (state)
            IDLE: begin
                if (ie) begin
                    next_state = FLUSH;
                end else if (is_iretd) begin
                    next_state = RET_FAR;
                end else begin
                    next_state = IDLE;
                end
            end
            FLUSH:       next_state = PUSH_EFLAGS;
            PUSH_EFLAGS: next_state = PUSH_CS;
            PUSH_CS:     next_state = PUSH_EIP;
            PUSH_EIP:    next_state = LOAD_LO;
            LOAD_LO:     next_state = LOAD_HI;
            LOAD_HI:     next_state = XCHG;
            XCHG:        next_state = SAR;
            SAR:         next_state = MOV_CS;
            MOV_CS:      next_state = JMP;
            JMP:         next_state = IDLE;
            RET_FAR:     next_state = POP_EFLAGS;     // IRETD path
            POP_EFLAGS:  next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    // Pipeline freeze holds everything
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else if (enable) begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctx_q  <= '0;
            gate_q <= '0;
        end else if (enable && capture) begin
            ctx_q  <= wb_ctx;
            gate_q <= gate;
        end
    end

    assign flush_pipe    = (state == FLUSH);
    assign packet_select = state inside {PUSH_EFLAGS, PUSH_CS, PUSH_EIP, LOAD_LO, LOAD_HI,
                                         XCHG, SAR, MOV_CS, JMP, RET_FAR, POP_EFLAGS};
    assign ld_eip        = state inside {JMP, RET_FAR};
    assign is_pop_eflags = (state == POP_EFLAGS);

    // Captured context stays fixed for the whole sequence
    a_no_accept_busy: assert property (
        @(posedge clk) disable iff (reset)
        (enable && state != IDLE) |=> ($stable(ctx_q) && $stable(gate_q))
    );

    // Flush stands alone and the first push follows it
    a_flush_alone: assert property (
        @(posedge clk) disable iff (reset)
        flush_pipe |-> !packet_select
    );

    a_flush_then_packet: assert property (
        @(posedge clk) disable iff (reset)
        (flush_pipe && enable) |=> (packet_select && !flush_pipe)
    );

endmodule

// File: design/packet_builder.sv
`include "idt_params.svh"

module packet_builder
    import idt_pkg::*;
(
    input  seq_state_t    state,
    input  wb_context_t   ctx_q,
    input  gate_addr_t    gate_q,
    output fetch_packet_u packet
);

    // Immediates go out little-endian
    function automatic logic [31:0] swap32(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    always_comb begin
        packet = '0;
        case (state)
            PUSH_EFLAGS: begin
                packet.imm_form.opcode = `OPC_PUSH_IMM;
                packet.imm_form.imm32  = swap32({14'd0, ctx_q.eflags});
            end
            PUSH_CS: begin
                packet.imm_form.opcode = `OPC_PUSH_IMM;
                packet.imm_form.imm32  = swap32({16'd0, ctx_q.cs});
            end
            PUSH_EIP: begin
                packet.imm_form.opcode = `OPC_PUSH_IMM;
                packet.imm_form.imm32  = swap32(ctx_q.eip);
            end
            LOAD_LO: begin
                packet.imm_form.opcode = `OPC_MOV_EAX_MOFFS;   // handler offset half
                packet.imm_form.imm32  = swap32(gate_q.entry_lo);
            end
            LOAD_HI: begin
                packet.imm_form.opcode = `OPC_MOV_EAX_MOFFS;
                packet.imm_form.imm32  = swap32(gate_q.entry_hi);
            end
            XCHG: begin
                {packet.raw[0], packet.raw[1]} = `OPC_XCHG_AX_BX;
            end
            SAR: begin
                {packet.raw[0], packet.raw[1], packet.raw[2]} = `OPC_SAR_EAX_4;
            end
            MOV_CS: begin
                {packet.raw[0], packet.raw[1], packet.raw[2]} = `OPC_MOV_CS_AX;
            end
            JMP: begin
                {packet.raw[0], packet.raw[1]} = `OPC_JMP_EBX;
            end
            RET_FAR: begin
                packet.raw[0] = `OPC_RET_FAR;
            end
            POP_EFLAGS: begin
                packet.raw[0] = `OPC_POP_EFLAGS;
            end
            default: begin
                packet = '0;    // IDLE and FLUSH
            end
        endcase
    end

endmodule

// File: files.f
+incdir+common
common/idt_pkg.sv
design/ie_decode.sv
design/ie_sequencer.sv
design/packet_builder.sv
design/idt_sequencer_top.sv
verification/tb_idt_sequencer.sv

// File: verification/tb_idt_sequencer.sv
`include "idt_params.svh"

module tb_idt_sequencer
    import idt_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 400;    // About 20 sequences with freezes

    logic          clk = 1'b0;
    logic          reset;
    logic          enable;
    logic          ie;
    ie_cause_t     ie_cause;
    logic [31:0]   idt_base;
    wb_context_t   wb_ctx;
    logic          is_iretd;
    fetch_packet_u packet;
    logic          packet_select;
    logic          flush_pipe;
    logic          ld_eip;
    logic          is_pop_eflags;

    integer seed = 32'h63ba_3d61;
    int     cycle_count = 0;

    // Model step: 0 idle, 1 flush, 2 to 10 interrupt packets, 11 and 12 IRETD
    int            exp_step;
    wb_context_t   exp_ctx;
    logic [31:0]   exp_entry;
    fetch_packet_u exp_packet;
    logic          exp_flush;
    logic          exp_select;
    logic          exp_ld_eip;
    logic          exp_pop;

    idt_sequencer_top idt_sequencer_top_inst (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .ie            (ie),
        .ie_cause      (ie_cause),
        .idt_base      (idt_base),
        .wb_ctx        (wb_ctx),
        .is_iretd      (is_iretd),
        .packet        (packet),
        .packet_select (packet_select),
        .flush_pipe    (flush_pipe),
        .ld_eip        (ld_eip),
        .is_pop_eflags (is_pop_eflags)
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_mismatch(input string name, input logic [127:0] got,
                                  input logic [127:0] exp);
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        stop_run();
    endtask

    function automatic logic [31:0] gate_vector(input ie_cause_t c);
        if (c.protection) return `IDT_VEC_PROTECTION;
        if (c.page_fault) return `IDT_VEC_PAGE_FAULT;
        return `IDT_VEC_INTERRUPT;
    endfunction

    function automatic fetch_packet_u imm_packet(input logic [7:0] opc, input logic [31:0] value);
        fetch_packet_u p;
        p = '0;
        p.raw[0] = opc;
        for (int i = 0; i < 4; i++) begin
            p.raw[1 + i] = value[8*i +: 8];     // Low byte first
        end
        return p;
    endfunction

    function automatic fetch_packet_u expected_packet(input int step, input wb_context_t c,
                                                      input logic [31:0] entry);
        fetch_packet_u p;
        p = '0;
        case (step)
            2:  p = imm_packet(`OPC_PUSH_IMM, 32'(c.eflags));
            3:  p = imm_packet(`OPC_PUSH_IMM, 32'(c.cs));
            4:  p = imm_packet(`OPC_PUSH_IMM, c.eip);
            5:  p = imm_packet(`OPC_MOV_EAX_MOFFS, entry);
            6:  p = imm_packet(`OPC_MOV_EAX_MOFFS, entry + 32'd4);
            7:  p.raw[0:1] = `OPC_XCHG_AX_BX;
            8:  p.raw[0:2] = `OPC_SAR_EAX_4;
            9:  p.raw[0:2] = `OPC_MOV_CS_AX;
            10: p.raw[0:1] = `OPC_JMP_EBX;
            11: p.raw[0] = `OPC_RET_FAR;
            12: p.raw[0] = `OPC_POP_EFLAGS;
            default: p = '0;
        endcase
        return p;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            exp_step  <= 0;
            exp_ctx   <= '0;
            exp_entry <= '0;
        end else if (enable) begin
            case (exp_step)
                0: begin
                    if (ie) begin
                        exp_step  <= 1;
                        exp_ctx   <= wb_ctx;
                        exp_entry <= idt_base + gate_vector(ie_cause) * 32'd8;
                    end else if (is_iretd) begin
                        exp_step <= 11;
                    end
                end
                10, 12:  exp_step <= 0;
                default: exp_step <= exp_step + 1;
            endcase
        end
    end

    always_comb begin
        exp_packet = expected_packet(exp_step, exp_ctx, exp_entry);
        exp_flush  = (exp_step == 1);
        exp_select = (exp_step >= 2);
        exp_ld_eip = (exp_step == 10) || (exp_step == 11);
        exp_pop    = (exp_step == 12);
    end

    a_packet: assert property (@(posedge clk) disable iff (reset) packet == exp_packet)
        else value_mismatch("packet", $sampled(packet), $sampled(exp_packet));
    a_flush: assert property (@(posedge clk) disable iff (reset) flush_pipe == exp_flush)
        else value_mismatch("flush_pipe", 128'($sampled(flush_pipe)), 128'($sampled(exp_flush)));
    a_select: assert property (@(posedge clk) disable iff (reset) packet_select == exp_select)
        else value_mismatch("packet_select", 128'($sampled(packet_select)),
                            128'($sampled(exp_select)));
    a_ld_eip: assert property (@(posedge clk) disable iff (reset) ld_eip == exp_ld_eip)
        else value_mismatch("ld_eip", 128'($sampled(ld_eip)), 128'($sampled(exp_ld_eip)));
    a_pop: assert property (@(posedge clk) disable iff (reset) is_pop_eflags == exp_pop)
        else value_mismatch("is_pop_eflags", 128'($sampled(is_pop_eflags)),
                            128'($sampled(exp_pop)));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    // New context and base every cycle, captured values must not follow
    task automatic scramble_inputs();
        wb_ctx.eip    = $random(seed);
        wb_ctx.cs     = 16'($random(seed));
        wb_ctx.eflags = 18'($random(seed));
        idt_base      = $random(seed);
    endtask

    // Runs until the last packet of the sequence has left
    task automatic finish_sequence(input bit iret, input bit gaps);
        bit   seen_last;
        bit   done;
        logic last_flag;
        seen_last = 1'b0;
        done      = 1'b0;
        while (!done) begin
            @(negedge clk);
            last_flag = iret ? is_pop_eflags : ld_eip;
            done      = seen_last && !last_flag;
            seen_last = seen_last || last_flag;
            is_iretd  = 1'b0;
            scramble_inputs();
            if (done) begin
                enable = 1'b1;
                ie     = 1'b0;
            end else begin
                enable = gaps ? (($random(seed) & 3) != 0) : 1'b1;
                ie     = gaps && (($random(seed) & 7) == 0);    // Stray request, ignored
            end
        end
    endtask

    task automatic run_interrupt(input logic [2:0] cause, input bit with_iretd, input bit gaps);
        @(negedge clk);
        enable   = 1'b1;
        ie       = 1'b1;
        is_iretd = with_iretd;
        ie_cause = ie_cause_t'(cause);
        scramble_inputs();
        finish_sequence(1'b0, gaps);
    endtask

    task automatic run_iretd(input bit gaps);
        @(negedge clk);
        enable   = 1'b1;
        is_iretd = 1'b1;
        finish_sequence(1'b1, gaps);
    endtask

    initial begin
        reset    = 1'b1;
        enable   = 1'b0;
        ie       = 1'b0;
        is_iretd = 1'b0;
        ie_cause = ie_cause_t'(3'b001);
        idt_base = '0;
        wb_ctx   = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            enable = 1'($random(seed));
        end
        for (int c = 1; c < 8; c++) begin
            run_interrupt(3'(c), 1'b0, 1'b0);
        end
        run_iretd(1'b0);
        // Same causes with pipeline freezes
        for (int c = 1; c < 8; c++) begin
            run_interrupt(3'(c), 1'b0, 1'b1);
        end
        repeat (2) run_iretd(1'b1);
        run_interrupt(3'b100, 1'b1, 1'b1);  // ie wins over is_iretd
        repeat (3) @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule
